// File: testbench/decodeStimulus.txt
// valid_instr_rsData_rtData_aluResult_flags{0,Z,N,V}_controls_fetchPc
// controls = {regWrite, memEnable, memWrite, memToReg, regSrc, halt, pcs, updatePc}
0_0000_0000_0000_0000_0_00_0002
1_0123_1234_0101_1335_0_80_0004
1_0123_7000_2000_7FFF_1_80_0006
1_1123_8000_0001_8000_3_80_0008
1_2123_00FF_00FF_0000_7_80_000A
1_1123_0005_0007_FFFE_2_80_000C
1_4124_1234_0000_2340_2_80_000E
1_5128_8400_0000_FF84_2_80_0010
1_6124_1234_0000_4123_2_80_0012
1_7123_7835_4812_7847_2_80_0014
1_8123_1000_0000_1006_2_D0_0016
1_912F_2000_0000_201E_2_60_0018
1_A1AB_1234_0000_12AB_2_88_001A
1_B1CD_1234_0000_CD34_2_88_001C
1_E100_0000_0000_001C_2_82_001E
1_F000_0000_0000_0000_2_04_001E
1_CFFF_0000_0000_0000_2_01_001C
0_0000_0000_0000_0000_2_00_001C
1_CFFF_0000_0000_0000_2_00_001C
1_CFFF_0000_0000_0000_2_00_001C
1_C3FF_0000_0000_0000_2_01_001E
0_0000_0000_0000_0000_2_00_0020
1_C400_0000_0000_0000_2_00_0022
1_C600_0000_0000_0000_2_01_0022
1_C800_0000_0000_0000_2_00_0024
1_CA00_0000_0000_0000_2_01_0024
1_C000_0000_0000_0000_2_01_0026
1_CC00_0000_0000_0000_2_00_0028
1_1123_1234_1234_0000_4_80_002A
1_C200_0000_0000_0000_4_01_002A
1_C400_0000_0000_0000_4_00_002C
1_C800_0000_0000_0000_4_01_002C
1_C000_0000_0000_0000_4_01_002E
1_DE00_0040_0000_0000_4_01_0040
0_0000_0000_0000_0000_4_00_0022
1_0123_7FFF_0001_7FFF_1_80_0024
1_CC00_0000_0000_0000_1_00_0026
1_C400_0000_0000_0000_1_01_0026
1_C600_0000_0000_0000_1_00_0028
0_0000_0000_0000_0000_1_00_002A

// File: project.f
hw/isaPkg.sv
hw/predictPkg.sv
hw/predictTable.sv
hw/branchPredictor.sv
hw/branchResolver.sv
hw/aluFlags.sv
hw/controlUnit.sv
hw/decodeSlice.sv
testbench/tbClockGen.sv
testbench/decodeSliceTb.sv

// File: Bender.yml
package:
  name: decode_slice

sources:
  - hw/isaPkg.sv
  - hw/predictPkg.sv
  - hw/predictTable.sv
  - hw/branchPredictor.sv
  - hw/branchResolver.sv
  - hw/aluFlags.sv
  - hw/controlUnit.sv
  - hw/decodeSlice.sv
  - target: test
    files:
      - testbench/tbClockGen.sv
      - testbench/decodeSliceTb.sv

// File: testbench/decodeSliceTb.sv
// Testbench for the decode and branch-resolution slice
// Replays stimulus vectors on falling edges and compares every output column
`timescale 1ns/1ps
`default_nettype none

module decodeSliceTb;
    import isaPkg::*;

    localparam int numVectors  = 40;
    localparam int cycleLimit  = numVectors + 20;      // Vectors plus reset and slack

    logic clk;
    logic rstN;
    logic instrValid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic [dataWidth-1:0] fetchPc;
    logic [dataWidth-1:0] aluResult;
    logic zFlag, nFlag, vFlag;
    logic regWrite, memEnable, memWrite, memToReg;
    logic regSrc, halt, pcs, updatePc;
    logic [7:0] ctrlBits;   // Same order as the control column
    logic [3:0] flagBits;   // {0, Z, N, V}

    logic [95:0] vectors [numVectors];
    int cycleCount = 0;

    tbClockGen clockGen (.clk, .rstN);

    decodeSlice #(.indexBits(3)) i_dut (
        .clk, .rstN, .instrValid, .instr, .rsData, .rtData,
        .fetchPc, .aluResult, .zFlag, .nFlag, .vFlag,
        .regWrite, .memEnable, .memWrite, .memToReg, .regSrc, .halt, .pcs, .updatePc
    );

    assign ctrlBits = {regWrite, memEnable, memWrite, memToReg, regSrc, halt, pcs, updatePc};
    assign flagBits = {1'b0, zFlag, nFlag, vFlag};

    ////////////////////////////////////////
    // Checking and run limit
    ////////////////////////////////////////
    task automatic compareValue(input string what, input logic [15:0] actual,
                                input logic [15:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("timeout: vectors did not finish");
            $display("*** FAILED ***");
            $fatal(1, "cycle limit reached");
        end
    end

    ////////////////////////////////////////
    // Vector replay
    ////////////////////////////////////////
    initial begin
        logic [95:0] vec;
        int i;
        instrValid = 1'b0;
        instr      = '0;
        rsData     = '0;
        rtData     = '0;
        $readmemh("testbench/decodeStimulus.txt", vectors);
        if ($isunknown(vectors[numVectors-1])) begin
            $display("Stimulus file is missing or holds fewer than %0d vectors", numVectors);
            $display("*** FAILED ***");
            $fatal(1, "no stimulus");
        end

        repeat (2) @(negedge clk);   // Mid reset
        compareValue("fetchPc in reset", fetchPc, 16'h0000);
        compareValue("flags in reset", 16'(flagBits), 16'h0000);
        compareValue("controls in reset", 16'(ctrlBits), 16'h0000);

        @(posedge rstN);   // Rises on a falling edge
        for (i = 0; i < numVectors; i++) begin
            vec        = vectors[i];
            instrValid = vec[92];
            instr      = vec[91:76];
            rsData     = vec[75:60];
            rtData     = vec[59:44];
            #2;   // Decode settles well before the rising edge
            compareValue($sformatf("vector %0d aluResult", i), aluResult, vec[43:28]);
            compareValue($sformatf("vector %0d controls", i), 16'(ctrlBits), 16'(vec[23:16]));
            @(negedge clk);   // Registered state after the edge
            compareValue($sformatf("vector %0d flags", i), 16'(flagBits), 16'(vec[27:24]));
            compareValue($sformatf("vector %0d fetchPc", i), fetchPc, vec[15:0]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tbClockGen.sv
// Clock and reset source for the decode slice testbench
// 8 ns clock, rstN held low for the first 4 rising edges
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int halfPeriod  = 4,   // ns
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;   // Release away from the active edge
    end

endmodule

`default_nettype wire

// File: hw/decodeSlice.sv
// Decode and branch-resolution slice of the 16-bit CPU
// Joins fetch prediction, control, branch resolution and the ALU
`timescale 1ns/1ps
`default_nettype none

module decodeSlice #(
    parameter int indexBits = 3   // BHT/BTB index width
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instrValid,
    input  logic [isaPkg::dataWidth-1:0] instr,
    input  logic [isaPkg::dataWidth-1:0] rsData,
    input  logic [isaPkg::dataWidth-1:0] rtData,
    output logic [isaPkg::dataWidth-1:0] fetchPc,
    output logic [isaPkg::dataWidth-1:0] aluResult,
    output logic                         zFlag,
    output logic                         nFlag,
    output logic                         vFlag,
    output logic                         regWrite,
    output logic                         memEnable,
    output logic                         memWrite,
    output logic                         memToReg,
    output logic                         regSrc,
    output logic                         halt,
    output logic                         pcs,
    output logic                         updatePc
);
    import isaPkg::*;

    logic [dataWidth-1:0] ifIdPc, ifIdPredTarget, actualTarget, redirectPc, aluOut;
    logic ifIdPredTaken, actualTaken;
    logic wenBtb, wenBht, aluSrc, zEn, nvEn;

    branchPredictor #(.indexBits(indexBits)) predictor (
        .clk, .rstN, .halt, .updatePc, .redirectPc, .wenBtb, .wenBht,
        .actualTaken, .actualTarget, .fetchPc, .ifIdPc, .ifIdPredTaken, .ifIdPredTarget
    );

    branchResolver resolver (
        .instr, .rsData, .ifIdPc, .zFlag, .nFlag, .vFlag, .actualTaken, .actualTarget
    );

    controlUnit control (
        .instrValid, .opcode(opcodeT'(instr[15:12])), .actualTaken,
        .predTaken(ifIdPredTaken), .predTarget(ifIdPredTarget), .actualTarget, .ifIdPc,
        .branch(), .wenBtb, .wenBht, .updatePc, .redirectPc, .aluSrc, .regSrc, .zEn, .nvEn,
        .memEnable, .memWrite, .regWrite, .memToReg, .halt, .pcs
    );

    aluFlags alu (
        .clk, .rstN, .instr, .rsData, .rtData, .aluSrc, .zEn, .nvEn,
        .aluResult(aluOut), .zFlag, .nFlag, .vFlag
    );

    assign aluResult = pcs ? ifIdPc + 16'd2 : aluOut;   // PCS returns the link address

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
// Control unit of the decode stage
// Decodes the opcode and judges the branch prediction against the outcome
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                         instrValid,
    input  isaPkg::opcodeT               opcode,
    input  logic                         actualTaken,
    input  logic                         predTaken,
    input  logic [isaPkg::dataWidth-1:0] predTarget,
    input  logic [isaPkg::dataWidth-1:0] actualTarget,
    input  logic [isaPkg::dataWidth-1:0] ifIdPc,
    output logic                         branch,
    output logic                         wenBtb,
    output logic                         wenBht,
    output logic                         updatePc,
    output logic [isaPkg::dataWidth-1:0] redirectPc,
    output logic                         aluSrc,
    output logic                         regSrc,
    output logic                         zEn,
    output logic                         nvEn,
    output logic                         memEnable,
    output logic                         memWrite,
    output logic                         regWrite,
    output logic                         memToReg,
    output logic                         halt,
    output logic                         pcs
);
    import isaPkg::*;

    logic mispredicted;   // Direction guessed wrong
    logic targetWrong;    // BTB target differs from actual

    assign mispredicted = predTaken != actualTaken;
    assign targetWrong  = predTarget != actualTarget;
    assign redirectPc   = actualTaken ? actualTarget : ifIdPc + 16'd2;   // Fall-through when not taken

    always_comb begin
        aluSrc    = 1'b0;
        regSrc    = 1'b0;
        zEn       = 1'b0;
        nvEn      = 1'b0;
        memEnable = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        halt      = 1'b0;
        pcs       = 1'b0;
        branch    = 1'b0;
        wenBtb    = 1'b0;
        wenBht    = 1'b0;
        updatePc  = 1'b0;
        if (instrValid) begin   // Bubble keeps everything idle
            regWrite = 1'b1;
            case (opcode)
                ADD, SUB: begin
                    zEn  = 1'b1;
                    nvEn = 1'b1;
                end
                XOR: zEn = 1'b1;
                SLL, SRA, ROR: begin
                    aluSrc = 1'b1;   // Shift amount from immediate
                    zEn    = 1'b1;
                end
                LW: begin
                    aluSrc    = 1'b1;
                    memEnable = 1'b1;
                    memToReg  = 1'b1;
                end
                SW: begin
                    aluSrc    = 1'b1;
                    memEnable = 1'b1;
                    memWrite  = 1'b1;
                    regWrite  = 1'b0;
                end
                LLB, LHB: begin
                    aluSrc = 1'b1;
                    regSrc = 1'b1;   // rd read on the rs port
                end
                B, BR: begin
                    branch   = 1'b1;
                    regWrite = 1'b0;
                    wenBht   = 1'b1;          // Train direction on every branch
                    wenBtb   = actualTaken;
                    updatePc = mispredicted || (actualTaken && targetWrong);
                end
                PCS: pcs = 1'b1;
                HLT: begin
                    halt     = 1'b1;
                    regWrite = 1'b0;
                end
                default: ;   // RED and PADDSB need only regWrite
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/aluFlags.sv
// ALU with the Z, N and V flag registers
// Saturating arithmetic, shifts, PADDSB, address and byte-load forms
`timescale 1ns/1ps
`default_nettype none

module aluFlags (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [isaPkg::dataWidth-1:0] instr,
    input  logic [isaPkg::dataWidth-1:0] rsData,
    input  logic [isaPkg::dataWidth-1:0] rtData,
    input  logic                         aluSrc,
    input  logic                         zEn,
    input  logic                         nvEn,
    output logic [isaPkg::dataWidth-1:0] aluResult,
    output logic                         zFlag,
    output logic                         nFlag,
    output logic                         vFlag
);
    import isaPkg::*;

    opcodeT op;
    logic [dataWidth-1:0] immWord;    // Immediate shaped per opcode
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic [3:0] shamt;
    logic overflow;                   // ADD or SUB saturated

    // Signed nibble add clamped to -8..7
    function automatic logic [3:0] satNibble(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] s;
        s = a + b;
        if (!a[3] && !b[3] && s[3]) return 4'h7;
        if (a[3] && b[3] && !s[3]) return 4'h8;
        return s;
    endfunction

    assign op    = opcodeT'(instr[15:12]);
    assign shamt = opB[3:0];

    always_comb begin
        case (op)
            LW, SW:   immWord = {11'b0, instr[3:0], 1'b0};   // Word offset times 2
            LLB, LHB: immWord = {8'b0, instr[7:0]};
            default:  immWord = {12'b0, instr[3:0]};
        endcase
    end

    assign opB  = aluSrc ? immWord : rtData;
    assign sum  = rsData + opB;
    assign diff = rsData - opB;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        aluResult = '0;
        overflow  = 1'b0;
        case (op)
            ADD: begin
                overflow  = (rsData[15] == opB[15]) && (sum[15] != rsData[15]);
                aluResult = overflow ? (rsData[15] ? 16'h8000 : 16'h7FFF) : sum;
            end
            SUB: begin
                overflow  = (rsData[15] != opB[15]) && (diff[15] != rsData[15]);
                aluResult = overflow ? (rsData[15] ? 16'h8000 : 16'h7FFF) : diff;
            end
            XOR:    aluResult = rsData ^ opB;
            SLL:    aluResult = rsData << shamt;
            SRA:    aluResult = $signed(rsData) >>> shamt;
            ROR:    aluResult = 16'({rsData, rsData} >> shamt);   // Rotate through a doubled word
            PADDSB: begin
                for (int i = 0; i < 4; i++) begin
                    aluResult[4*i +: 4] = satNibble(rsData[4*i +: 4], opB[4*i +: 4]);
                end
            end
            LW, SW: aluResult = sum;                       // Effective address
            LLB:    aluResult = {rsData[15:8], opB[7:0]};
            LHB:    aluResult = {opB[7:0], rsData[7:0]};
            default: aluResult = '0;                        // RED and control ops
        endcase
    end

    ////////////////////////////////////////
    // Flags
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            zFlag <= 1'b0;
            nFlag <= 1'b0;
            vFlag <= 1'b0;
        end else begin
            if (zEn) zFlag <= (aluResult == '0);
            if (nvEn) begin
                nFlag <= aluResult[15];
                vFlag <= overflow;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/branchResolver.sv
// Branch resolution
// Evaluates the condition field against the flags and forms the target
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  logic [isaPkg::dataWidth-1:0] instr,
    input  logic [isaPkg::dataWidth-1:0] rsData,
    input  logic [isaPkg::dataWidth-1:0] ifIdPc,
    input  logic                         zFlag,
    input  logic                         nFlag,
    input  logic                         vFlag,
    output logic                         actualTaken,
    output logic [isaPkg::dataWidth-1:0] actualTarget
);
    import isaPkg::*;

    condT cond;
    logic gtTrue;
    logic [dataWidth-1:0] offsetTarget;

    assign cond   = condT'(instr[11:9]);   // ccc field
    assign gtTrue = !zFlag && !nFlag;

    always_comb begin
        unique case (cond)
            NEQ:     actualTaken = !zFlag;
            EQ:      actualTaken = zFlag;
            GT:      actualTaken = gtTrue;
            LT:      actualTaken = nFlag;
            GTE:     actualTaken = gtTrue || zFlag;
            LTE:     actualTaken = nFlag || zFlag;
            OVFL:    actualTaken = vFlag;
            default: actualTaken = 1'b1;   // UNCOND
        endcase
    end

    // PC + 2 + signed 9-bit halfword offset
    assign offsetTarget = ifIdPc + 16'd2 + {{6{instr[8]}}, instr[8:0], 1'b0};
    assign actualTarget = (opcodeT'(instr[15:12]) == BR) ? rsData : offsetTarget;

endmodule

`default_nettype wire

// File: hw/branchPredictor.sv
// Fetch PC with BHT/BTB prediction and the IF/ID register
// Trains the BHT counters and BTB targets from the resolved branch
`timescale 1ns/1ps
`default_nettype none

module branchPredictor #(
    parameter int indexBits = 3
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         halt,
    input  logic                         updatePc,
    input  logic [isaPkg::dataWidth-1:0] redirectPc,
    input  logic                         wenBtb,
    input  logic                         wenBht,
    input  logic                         actualTaken,
    input  logic [isaPkg::dataWidth-1:0] actualTarget,
    output logic [isaPkg::dataWidth-1:0] fetchPc,
    output logic [isaPkg::dataWidth-1:0] ifIdPc,
    output logic                         ifIdPredTaken,
    output logic [isaPkg::dataWidth-1:0] ifIdPredTarget
);
    import predictPkg::*;

    counterT fetchCounter;    // BHT entry at fetchPc
    counterT ifIdCounter;     // Counter seen at fetch, kept for training
    counterT trainedCounter;
    targetT  btbTarget;
    targetT  nextPc;

    ////////////////////////////////////////
    // Tables
    ////////////////////////////////////////
    predictTable #(.indexBits(indexBits), .entryT(counterT), .resetValue(counterReset)) bht (
        .clk, .rstN,
        .rdIndex(fetchPc[indexBits:1]), .rdData(fetchCounter),   // Bit 0 is always zero
        .wen(wenBht), .wrIndex(ifIdPc[indexBits:1]), .wrData(trainedCounter)
    );

    predictTable #(.indexBits(indexBits), .entryT(targetT), .resetValue(targetReset)) btb (
        .clk, .rstN,
        .rdIndex(fetchPc[indexBits:1]), .rdData(btbTarget),
        .wen(wenBtb), .wrIndex(ifIdPc[indexBits:1]), .wrData(actualTarget)
    );

    // Saturating step toward the resolved direction
    always_comb begin
        trainedCounter = ifIdCounter;
        if (actualTaken && ifIdCounter != 2'b11) trainedCounter = ifIdCounter + 2'd1;
        if (!actualTaken && ifIdCounter != 2'b00) trainedCounter = ifIdCounter - 2'd1;
    end

    assign nextPc = fetchCounter[1] ? btbTarget : fetchPc + 16'd2;   // Upper bit predicts taken

    ////////////////////////////////////////
    // Fetch PC and IF/ID
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPc        <= '0;
            ifIdPc         <= '0;
            ifIdCounter    <= '0;
            ifIdPredTarget <= '0;
        end else begin
            if (updatePc) fetchPc <= redirectPc;   // Redirect beats halt
            else if (!halt) fetchPc <= nextPc;
            if (!halt) begin
                ifIdPc         <= fetchPc;
                ifIdCounter    <= fetchCounter;
                ifIdPredTarget <= btbTarget;
            end
        end
    end

    assign ifIdPredTaken = ifIdCounter[1];

    // Instructions are halfword aligned, so fetch never goes odd
    fetchPcEven: assert property (@(posedge clk) disable iff (!rstN) !fetchPc[0]);

endmodule

`default_nettype wire

// File: hw/predictTable.sv
// Small direct-mapped predictor table
// Asynchronous read, synchronous write, reset to a fixed entry value
`timescale 1ns/1ps
`default_nettype none

module predictTable #(
    parameter int indexBits = 3,
    parameter type entryT = logic,
    parameter entryT resetValue = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [indexBits-1:0] rdIndex,
    output entryT                rdData,
    input  logic                 wen,
    input  logic [indexBits-1:0] wrIndex,
    input  entryT                wrData
);

    entryT entries [2**indexBits];   // Table storage

    assign rdData = entries[rdIndex];   // Read in the fetch cycle

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**indexBits; i++) begin
                entries[i] <= resetValue;
            end
        end else if (wen) begin
            entries[wrIndex] <= wrData;   // Lands at the edge
        end
    end

    // A training write carries a resolved value
    wrDataKnown: assert property (@(posedge clk) disable iff (!rstN) wen |-> !$isunknown(wrData));

endmodule

`default_nettype wire

// File: hw/predictPkg.sv
// Predictor table types
// Entry formats and reset values of the BHT and BTB
`default_nettype none

package predictPkg;

    typedef logic [1:0] counterT;                        // 2-bit saturating counter
    typedef logic [isaPkg::dataWidth-1:0] targetT;       // BTB entry

    localparam counterT counterReset = 2'b01;            // Weakly not taken
    localparam targetT targetReset = '0;

endpackage

`default_nettype wire

// File: hw/isaPkg.sv
// ISA definitions for the 16-bit load/store CPU
// Data width, opcode map and branch condition codes
`default_nettype none

package isaPkg;

    localparam int dataWidth = 16;    // Data and address width

    typedef enum logic [3:0] {
        ADD, SUB, XOR, RED,           // Arithmetic and logic
        SLL, SRA, ROR, PADDSB,        // Shifts and packed add
        LW, SW, LLB, LHB,             // Memory and byte loads
        B, BR, PCS, HLT               // Control flow
    } opcodeT;

    typedef enum logic [2:0] {
        NEQ, EQ, GT, LT,
        GTE, LTE, OVFL, UNCOND        // Condition field of B and BR
    } condT;

endpackage

`default_nettype wire
